// ==== design/i2c_config.svh ====
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

////////////////////
// Bus timing
////////////////////

// System clocks per quarter of an SCL period
// One bit on the wire spans four quarters
`define I2C_QUARTER_DIV 4

////////////////////
// Host side
////////////////////

// Clients sharing the single byte master
`define I2C_NUM_CLIENTS 2

`endif

// ==== design/i2c_pkg.sv ====
`default_nettype none

`include "i2c_config.svh"

package i2c_pkg;

	// Target address without the R/W bit
	typedef logic [6:0] i2c_addr_t;

	typedef logic [7:0] i2c_data_t;

	// Wide enough to name every client
	typedef logic [$clog2(`I2C_NUM_CLIENTS)-1:0] client_idx_t;

	// Byte master sequence, one state per field on the wire
	typedef enum logic [3:0] {
		IDLE,
		START,
		ADDR,
		ADDR_ACK,
		WDATA,
		WDATA_ACK,
		RDATA,
		RDATA_ACK,
		STOP
	} master_state_t;

endpackage

`default_nettype wire

// ==== design/i2c_client_arbiter.sv ====
`default_nettype none

`include "i2c_config.svh"

module i2c_client_arbiter (
	input  logic                              clk_i,
	input  logic                              rst,
	input  logic [`I2C_NUM_CLIENTS-1:0]       req_i,
	input  logic [`I2C_NUM_CLIENTS-1:0]       write_i,
	input  i2c_pkg::i2c_addr_t                addr_i [`I2C_NUM_CLIENTS],
	input  i2c_pkg::i2c_data_t                wdata_i [`I2C_NUM_CLIENTS],
	output logic [`I2C_NUM_CLIENTS-1:0]       done_o,
	output logic [`I2C_NUM_CLIENTS-1:0]       nack_o,
	output i2c_pkg::i2c_data_t                rdata_o [`I2C_NUM_CLIENTS],
	output logic                              start_o,
	output logic                              cmd_write_o,
	output i2c_pkg::i2c_addr_t                cmd_addr_o,
	output i2c_pkg::i2c_data_t                cmd_wdata_o,
	input  logic                              busy_i,
	input  logic                              finish_i,
	input  logic                              ack_err_i,
	input  i2c_pkg::i2c_data_t                rd_byte_i,
	output logic                              ready_o
);
	import i2c_pkg::*;

	// Client 0 wins the first round after reset
	localparam client_idx_t LAST_INIT = client_idx_t'(`I2C_NUM_CLIENTS - 1);

	logic        granted_q;
	client_idx_t grant_idx_q;
	client_idx_t last_q;
	logic        sel_found;
	client_idx_t sel_idx;

	// Search starts one past the client served last
	// A client whose done_o is up still holds req_i for that cycle, so it is skipped
	always_comb begin
		client_idx_t cand;
		sel_found = 1'b0;
		sel_idx = last_q;
		for (int i = 1; i <= `I2C_NUM_CLIENTS; i++) begin
			cand = client_idx_t'((int'(last_q) + i) % `I2C_NUM_CLIENTS);
			if (!sel_found && req_i[cand] && !done_o[cand]) begin
				sel_found = 1'b1;
				sel_idx = cand;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst) begin
			granted_q <= 1'b0;
			grant_idx_q <= '0;
			last_q <= LAST_INIT;
			start_o <= 1'b0;
			done_o <= '0;
			nack_o <= '0;
		end else begin
			start_o <= 1'b0;
			done_o <= '0;
			if (!granted_q) begin
				if (sel_found && !busy_i) begin
					granted_q <= 1'b1;
					grant_idx_q <= sel_idx;
					start_o <= 1'b1;
				end
			end else if (finish_i) begin
				granted_q <= 1'b0;
				last_q <= grant_idx_q;
				done_o[grant_idx_q] <= 1'b1;
				nack_o[grant_idx_q] <= ack_err_i;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (granted_q && finish_i) begin
			rdata_o[grant_idx_q] <= rd_byte_i;
		end
	end

	// The client holds its fields until done_o, so they go straight to the master
	assign cmd_write_o = write_i[grant_idx_q];
	assign cmd_addr_o = addr_i[grant_idx_q];
	assign cmd_wdata_o = wdata_i[grant_idx_q];

	assign ready_o = !busy_i && !granted_q;

	// A launched command owns the master until its finish pulse
	a_one_grant: assert property (@(posedge clk_i) disable iff (!rst)
		start_o |=> ((busy_i && !start_o) until finish_i));

	a_start_idle: assert property (@(posedge clk_i) disable iff (!rst)
		start_o |-> !busy_i);

endmodule

`default_nettype wire

// ==== design/i2c_scl_timer.sv ====
`default_nettype none

`include "i2c_config.svh"

module i2c_scl_timer (
	input  logic clk_i,
	input  logic rst,
	input  logic run_i,
	output logic tick_o
);

	localparam int CNT_W = $clog2(`I2C_QUARTER_DIV + 1);
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`I2C_QUARTER_DIV - 1);
	localparam logic [CNT_W-1:0] ONE = CNT_W'(1);

	logic [CNT_W-1:0] cnt_q;

	////////////////////
	// Quarter counter
	////////////////////

	// Zero means freshly cleared, so the first run cycle only loads
	// The tick fires as the count steps from one down to zero
	always_ff @(posedge clk_i) begin
		if (!rst || !run_i) begin
			cnt_q <= '0;
			tick_o <= 1'b0;
		end else begin
			tick_o <= (cnt_q == ONE);
			if (cnt_q == '0) begin
				cnt_q <= RELOAD;
			end else begin
				cnt_q <= cnt_q - ONE;
			end
		end
	end

	// Ticks keep a fixed spacing while the master runs
	a_tick_period: assert property (@(posedge clk_i) disable iff (!rst)
		(tick_o && run_i) |=> !tick_o [*(`I2C_QUARTER_DIV - 1)]);

endmodule

`default_nettype wire

// ==== design/i2c_byte_master.sv ====
`default_nettype none

module i2c_byte_master (
	input  logic               clk_i,
	input  logic               rst,
	input  logic               start_i,
	input  logic               cmd_write_i,
	input  i2c_pkg::i2c_addr_t cmd_addr_i,
	input  i2c_pkg::i2c_data_t cmd_wdata_i,
	input  logic               tick_i,
	output logic               run_o,
	output logic               busy_o,
	output logic               finish_o,
	output logic               ack_err_o,
	output i2c_pkg::i2c_data_t rd_byte_o,
	output logic               scl_oe_o,
	output logic               sda_oe_o,
	input  logic               scl_i,
	input  logic               sda_i
);
	import i2c_pkg::*;

	master_state_t state;
	master_state_t next_state;
	logic [1:0]    phase;
	logic [2:0]    bit_cnt;
	logic          write_q;
	i2c_data_t     wdata_q;
	i2c_data_t     sh_q;
	logic [1:0]    scl_sync_q;
	logic [1:0]    sda_sync_q;
	logic          scl_sync;
	logic          sda_sync;
	logic          sda_drive;
	logic          last_bit;

	////////////////////
	// Line inputs
	////////////////////

	always_ff @(posedge clk_i) begin
		scl_sync_q <= {scl_sync_q[0], scl_i};
		sda_sync_q <= {sda_sync_q[0], sda_i};
	end

	assign scl_sync = scl_sync_q[1];
	assign sda_sync = sda_sync_q[1];

	////////////////////
	// Sequencing
	////////////////////

	assign last_bit = (bit_cnt == 3'd7);

	// Address and write bits pull SDA for a zero
	// Acknowledge slots and read bits leave the line to the target, and the master NACKs a read
	always_comb begin
		case (state)
			ADDR, WDATA: sda_drive = ~sh_q[7];
			default:     sda_drive = 1'b0;
		endcase
	end

	// Where a bit slot leads once its fourth quarter ends
	always_comb begin
		next_state = state;
		case (state)
			ADDR:      if (last_bit) next_state = ADDR_ACK;
			ADDR_ACK:  next_state = ack_err_o ? STOP : (write_q ? WDATA : RDATA);
			WDATA:     if (last_bit) next_state = WDATA_ACK;
			WDATA_ACK: next_state = STOP;
			RDATA:     if (last_bit) next_state = RDATA_ACK;
			RDATA_ACK: next_state = STOP;
			default:   next_state = state;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst) begin
			state <= IDLE;
			phase <= '0;
			bit_cnt <= '0;
			scl_oe_o <= 1'b0;
			sda_oe_o <= 1'b0;
			finish_o <= 1'b0;
			ack_err_o <= 1'b0;
		end else begin
			finish_o <= 1'b0;
			if (state == IDLE) begin
				phase <= '0;
				bit_cnt <= '0;
				if (start_i) begin
					state <= START;
					ack_err_o <= 1'b0;
				end
			end else if (tick_i) begin
				phase <= phase + 2'd1;
				case (state)
					START: begin
						// SDA falls while SCL is still high
						if (phase == 2'd2) begin
							sda_oe_o <= 1'b1;
						end
						if (phase == 2'd3) begin
							scl_oe_o <= 1'b1;
							state <= ADDR;
						end
					end
					STOP: begin
						case (phase)
							2'd0: sda_oe_o <= 1'b1;
							2'd1: scl_oe_o <= 1'b0;
							2'd2: sda_oe_o <= 1'b0;
							default: begin
								state <= IDLE;
								finish_o <= 1'b1;
							end
						endcase
					end
					ADDR, ADDR_ACK, WDATA, WDATA_ACK, RDATA, RDATA_ACK: begin
						case (phase)
							2'd0: sda_oe_o <= sda_drive;
							2'd1: scl_oe_o <= 1'b0;
							2'd2: begin
								// A released SDA or a held SCL both count as no acknowledge
								if ((state == ADDR_ACK || state == WDATA_ACK) &&
										(sda_sync || !scl_sync)) begin
									ack_err_o <= 1'b1;
								end
							end
							default: begin
								scl_oe_o <= 1'b1;
								state <= next_state;
								if (state == ADDR || state == WDATA || state == RDATA) begin
									bit_cnt <= bit_cnt + 3'd1;
								end
							end
						endcase
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	////////////////////
	// Shift path
	////////////////////

	always_ff @(posedge clk_i) begin
		if (state == IDLE && start_i) begin
			// R/W bit is high for a read
			sh_q <= {cmd_addr_i, ~cmd_write_i};
			write_q <= cmd_write_i;
			wdata_q <= cmd_wdata_i;
		end else if (tick_i) begin
			if (phase == 2'd2 && state == RDATA) begin
				sh_q <= {sh_q[6:0], sda_sync};
			end
			if (phase == 2'd3) begin
				if (state == ADDR || state == WDATA) begin
					sh_q <= sh_q << 1;
				end
				if (state == ADDR_ACK) begin
					sh_q <= wdata_q;
				end
				if (state == RDATA && last_bit) begin
					rd_byte_o <= sh_q;
				end
			end
		end
	end

	assign run_o = (state != IDLE);
	assign busy_o = (state != IDLE);

	// SDA moves only while SCL is low, apart from the start and stop conditions
	a_sda_phase: assert property (@(posedge clk_i) disable iff (!rst)
		$changed(sda_oe_o) |-> ($past(phase) == 2'd0 || $past(state) inside {START, STOP}));

endmodule

`default_nettype wire

// ==== design/i2c_bus_subsystem.sv ====
`default_nettype none

`include "i2c_config.svh"

module i2c_bus_subsystem (
	input  logic                        clk_i,
	input  logic                        rst,
	input  logic [`I2C_NUM_CLIENTS-1:0] req_i,
	input  logic [`I2C_NUM_CLIENTS-1:0] write_i,
	input  i2c_pkg::i2c_addr_t          addr_i [`I2C_NUM_CLIENTS],
	input  i2c_pkg::i2c_data_t          wdata_i [`I2C_NUM_CLIENTS],
	output logic [`I2C_NUM_CLIENTS-1:0] done_o,
	output logic [`I2C_NUM_CLIENTS-1:0] nack_o,
	output i2c_pkg::i2c_data_t          rdata_o [`I2C_NUM_CLIENTS],
	output logic                        ready_o,
	output logic                        scl_oe_o,
	output logic                        sda_oe_o,
	input  logic                        scl_i,
	input  logic                        sda_i
);
	import i2c_pkg::*;

	logic      start;
	logic      cmd_write;
	i2c_addr_t cmd_addr;
	i2c_data_t cmd_wdata;
	logic      busy;
	logic      finish;
	logic      ack_err;
	i2c_data_t rd_byte;
	logic      run;
	logic      tick;

	i2c_client_arbiter i2c_client_arbiter_i (
		.clk_i       (clk_i),
		.rst         (rst),
		.req_i       (req_i),
		.write_i     (write_i),
		.addr_i      (addr_i),
		.wdata_i     (wdata_i),
		.done_o      (done_o),
		.nack_o      (nack_o),
		.rdata_o     (rdata_o),
		.start_o     (start),
		.cmd_write_o (cmd_write),
		.cmd_addr_o  (cmd_addr),
		.cmd_wdata_o (cmd_wdata),
		.busy_i      (busy),
		.finish_i    (finish),
		.ack_err_i   (ack_err),
		.rd_byte_i   (rd_byte),
		.ready_o     (ready_o)
	);

	i2c_scl_timer i2c_scl_timer_i (
		.clk_i  (clk_i),
		.rst    (rst),
		.run_i  (run),
		.tick_o (tick)
	);

	i2c_byte_master i2c_byte_master_i (
		.clk_i       (clk_i),
		.rst         (rst),
		.start_i     (start),
		.cmd_write_i (cmd_write),
		.cmd_addr_i  (cmd_addr),
		.cmd_wdata_i (cmd_wdata),
		.tick_i      (tick),
		.run_o       (run),
		.busy_o      (busy),
		.finish_o    (finish),
		.ack_err_o   (ack_err),
		.rd_byte_o   (rd_byte),
		.scl_oe_o    (scl_oe_o),
		.sda_oe_o    (sda_oe_o),
		.scl_i       (scl_i),
		.sda_i       (sda_i)
	);

endmodule

`default_nettype wire

// ==== bench/i2c_target_model.sv ====
`default_nettype none

module i2c_target_model #(
	parameter logic [6:0] ADDR = 7'h2c,
	parameter logic [7:0] INIT_BYTE = 8'h00
) (
	input  logic       scl_i,
	input  logic       sda_i,
	output logic       sda_oe_o,
	output logic [7:0] stored_o
);

	typedef enum {
		T_IDLE,
		T_ADDR,
		T_ADDR_ACK,
		T_WRITE,
		T_WRITE_ACK,
		T_READ,
		T_READ_ACK
	} target_state_t;

	target_state_t state = T_IDLE;
	logic [7:0]    shift = '0;
	int            bit_cnt = 0;
	logic          rw = 1'b0;
	logic          scl_q = 1'b1;
	logic          sda_q = 1'b1;

	initial begin
		sda_oe_o = 1'b0;
		stored_o = INIT_BYTE;
	end

	// Start and stop are SDA edges while SCL is high, all else follows SCL
	always @(scl_i or sda_i) begin
		if (scl_i && scl_q && sda_q && !sda_i) begin
			state = T_ADDR;
			bit_cnt = 0;
			sda_oe_o = 1'b0;
		end else if (scl_i && scl_q && !sda_q && sda_i) begin
			state = T_IDLE;
			sda_oe_o = 1'b0;
		end else if (scl_i && !scl_q) begin
			if (state == T_ADDR || state == T_WRITE) begin
				shift = {shift[6:0], sda_i};
				bit_cnt++;
			end
		end else if (!scl_i && scl_q) begin
			// The line only changes while SCL is low
			case (state)
				T_ADDR: if (bit_cnt == 8) begin
					rw = shift[0];
					sda_oe_o = (shift[7:1] == ADDR);
					state = (shift[7:1] == ADDR) ? T_ADDR_ACK : T_IDLE;
				end
				T_ADDR_ACK: begin
					bit_cnt = 0;
					shift = stored_o;
					sda_oe_o = rw && !stored_o[7];
					state = rw ? T_READ : T_WRITE;
				end
				T_WRITE: if (bit_cnt == 8) begin
					stored_o = shift;
					sda_oe_o = 1'b1;
					state = T_WRITE_ACK;
				end
				T_READ: begin
					shift = shift << 1;
					bit_cnt++;
					sda_oe_o = (bit_cnt < 8) && !shift[7];
					if (bit_cnt == 8) begin
						state = T_READ_ACK;
					end
				end
				default: begin
					sda_oe_o = 1'b0;
					state = T_IDLE;
				end
			endcase
		end
		scl_q = scl_i;
		sda_q = sda_i;
	end

endmodule

`default_nettype wire

// ==== bench/i2c_bus_subsystem_tb.sv ====
`default_nettype none

`include "i2c_config.svh"

module i2c_bus_subsystem_tb;
	import i2c_pkg::*;

	localparam i2c_addr_t TARGET_ADDR = 7'h2c;
	localparam i2c_addr_t OTHER_ADDR = 7'h13;
	localparam i2c_data_t TARGET_INIT = 8'ha5;
	localparam int TIMEOUT_CYCLES = 1000;
	localparam int MAX_ROWS = 32;

	typedef struct packed {
		client_idx_t client;
		logic        write;
		i2c_addr_t   addr;
		i2c_data_t   data;
		logic        exp_nack;
		i2c_data_t   exp_rdata;
		logic        with_next;
	} row_t;

	logic                        clk;
	logic                        rst;
	logic [`I2C_NUM_CLIENTS-1:0] req;
	logic [`I2C_NUM_CLIENTS-1:0] write;
	i2c_addr_t                   addr [`I2C_NUM_CLIENTS];
	i2c_data_t                   wdata [`I2C_NUM_CLIENTS];
	logic [`I2C_NUM_CLIENTS-1:0] done;
	logic [`I2C_NUM_CLIENTS-1:0] nack;
	i2c_data_t                   rdata [`I2C_NUM_CLIENTS];
	logic                        ready;
	logic                        scl_oe;
	logic                        sda_oe;
	logic                        target_sda_oe;
	i2c_data_t                   target_byte;
	logic                        scl;
	logic                        sda;

	row_t      table_q [MAX_ROWS];
	int        n_rows;
	int        errors;
	int        checks;
	int        last_served;
	logic      timed_out;
	i2c_data_t model_byte;
	integer    seed;
	int        rnd;
	int        r;

	i2c_bus_subsystem i2c_bus_subsystem_i (
		.clk_i    (clk),
		.rst      (rst),
		.req_i    (req),
		.write_i  (write),
		.addr_i   (addr),
		.wdata_i  (wdata),
		.done_o   (done),
		.nack_o   (nack),
		.rdata_o  (rdata),
		.ready_o  (ready),
		.scl_oe_o (scl_oe),
		.sda_oe_o (sda_oe),
		.scl_i    (scl),
		.sda_i    (sda)
	);

	i2c_target_model #(.ADDR(TARGET_ADDR), .INIT_BYTE(TARGET_INIT)) i2c_target_model_i (
		.scl_i    (scl),
		.sda_i    (sda),
		.sda_oe_o (target_sda_oe),
		.stored_o (target_byte)
	);

	// Open-drain lines float high unless someone pulls them
	assign scl = (scl_oe === 1'b1) ? 1'b0 : 1'b1;
	assign sda = (sda_oe === 1'b1 || target_sda_oe === 1'b1) ? 1'b0 : 1'b1;

	always #5 clk = ~clk;

	task automatic add_row(input client_idx_t client, input logic wr, input i2c_addr_t a,
			input i2c_data_t d, input logic exp_nack, input i2c_data_t exp_rdata,
			input logic with_next);
		table_q[n_rows] = {client, wr, a, d, exp_nack, exp_rdata, with_next};
		n_rows++;
	endtask

	task automatic check_result(input int idx);
		row_t row;
		row = table_q[idx];
		checks++;
		if (nack[row.client] !== row.exp_nack) begin
			errors++;
			$display("mismatch at %0t: row %0d nack_o %b, expected %b",
				$time, idx, nack[row.client], row.exp_nack);
		end
		if (!row.exp_nack && !row.write) begin
			checks++;
			if (rdata[row.client] !== row.exp_rdata) begin
				errors++;
				$display("mismatch at %0t: row %0d rdata_o %h, expected %h",
					$time, idx, rdata[row.client], row.exp_rdata);
			end
		end
		// An acknowledged write replaces the byte, anything else leaves it alone
		if (!row.exp_nack && row.write) begin
			model_byte = row.data;
		end
		checks++;
		if (target_byte !== model_byte) begin
			errors++;
			$display("mismatch at %0t: row %0d target byte %h, expected %h",
				$time, idx, target_byte, model_byte);
		end
	endtask

	// One row, or two rows on both clients raised in the same cycle
	task automatic serve_rows(input int first, input int count);
		int                          row_of [`I2C_NUM_CLIENTS];
		logic [`I2C_NUM_CLIENTS-1:0] active;
		int                          expect_first;
		int                          waited;
		int                          served;
		row_t                        row;
		active = '0;
		served = 0;
		waited = 0;
		expect_first = (last_served + 1) % `I2C_NUM_CLIENTS;
		for (int k = 0; k < count; k++) begin
			row = table_q[first + k];
			row_of[row.client] = first + k;
			active[row.client] = 1'b1;
			req[row.client] = 1'b1;
			write[row.client] = row.write;
			addr[row.client] = row.addr;
			wdata[row.client] = row.data;
		end
		while (served < count && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
			// A served client lets go of req_i one cycle after its done_o
			req = req & active;
			for (int c = 0; c < `I2C_NUM_CLIENTS; c++) begin
				if (done[c] === 1'b1 && !active[c]) begin
					errors++;
					$display("client %0d raised done_o with no request pending", c);
				end else if (done[c] === 1'b1) begin
					if (count > 1 && served == 0 && last_served >= 0) begin
						checks++;
						if (c != expect_first) begin
							errors++;
							$display("mismatch at %0t: client %0d finished first, expected %0d",
								$time, c, expect_first);
						end
					end
					check_result(row_of[c]);
					active[c] = 1'b0;
					served++;
					last_served = c;
					waited = 0;
				end
			end
		end
		if (served < count) begin
			errors++;
			timed_out = 1'b1;
			$display("row %0d: transaction never completed within %0d cycles",
				first + served, TIMEOUT_CYCLES);
		end else begin
			@(negedge clk);
			req = req & active;
			@(negedge clk);
			checks++;
			if (ready !== 1'b1) begin
				errors++;
				$display("mismatch at %0t: ready_o %b after row %0d", $time, ready, first);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		req = '0;
		write = '0;
		for (int c = 0; c < `I2C_NUM_CLIENTS; c++) begin
			addr[c] = '0;
			wdata[c] = '0;
		end
		n_rows = 0;
		errors = 0;
		checks = 0;
		last_served = -1;
		timed_out = 1'b0;
		model_byte = TARGET_INIT;
		seed = 32'h2b79;

		////////////////////
		// Stimulus table
		////////////////////
		add_row(0, 1, TARGET_ADDR, 8'h5a, 0, 8'h00, 0);
		add_row(1, 0, TARGET_ADDR, 8'h00, 0, 8'h5a, 0);
		add_row(1, 1, TARGET_ADDR, 8'hc3, 0, 8'h00, 0);
		add_row(0, 0, TARGET_ADDR, 8'h00, 0, 8'hc3, 0);
		add_row(0, 1, OTHER_ADDR, 8'h11, 1, 8'h00, 0);
		add_row(1, 0, OTHER_ADDR, 8'h00, 1, 8'h00, 0);
		add_row(1, 0, TARGET_ADDR, 8'h00, 0, 8'hc3, 0);
		// Client 1 went last, so client 0 leads this pair
		add_row(0, 1, TARGET_ADDR, 8'h96, 0, 8'h00, 1);
		add_row(1, 1, TARGET_ADDR, 8'h69, 0, 8'h00, 0);
		add_row(0, 1, TARGET_ADDR, 8'h3c, 0, 8'h00, 0);
		add_row(0, 1, OTHER_ADDR, 8'hff, 1, 8'h00, 1);
		add_row(1, 0, TARGET_ADDR, 8'h00, 0, 8'h3c, 0);
		for (int k = 0; k < 4; k++) begin
			rnd = $random(seed);
			add_row(k % 2, 1, TARGET_ADDR, rnd[7:0], 0, 8'h00, 0);
			add_row((k + 1) % 2, 0, TARGET_ADDR, 8'h00, 0, rnd[7:0], 0);
		end

		repeat (10) @(negedge clk);
		rst = 1'b1;
		repeat (4) begin
			@(negedge clk);
			checks++;
			if (ready !== 1'b1 || scl_oe !== 1'b0 || sda_oe !== 1'b0 || done !== '0) begin
				errors++;
				$display("mismatch at %0t: idle ready_o %b scl_oe_o %b sda_oe_o %b done_o %b",
					$time, ready, scl_oe, sda_oe, done);
			end
		end

		r = 0;
		while (r < n_rows && !timed_out) begin
			if (table_q[r].with_next) begin
				serve_rows(r, 2);
				r += 2;
			end else begin
				serve_rows(r, 1);
				r += 1;
			end
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+design
design/i2c_pkg.sv
design/i2c_client_arbiter.sv
design/i2c_scl_timer.sv
design/i2c_byte_master.sv
design/i2c_bus_subsystem.sv
bench/i2c_target_model.sv
bench/i2c_bus_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: i2c_bus_subsystem

sources:
  - include_dirs:
      - design
    files:
      - design/i2c_pkg.sv
      - design/i2c_client_arbiter.sv
      - design/i2c_scl_timer.sv
      - design/i2c_byte_master.sv
      - design/i2c_bus_subsystem.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/i2c_target_model.sv
      - bench/i2c_bus_subsystem_tb.sv
